//--- nebula_pkg.sv
// ##########################################################
// Shared Wishbone bus types, address union, region codes,
// width constants and the byte-lane merge helper
// ##########################################################

package nebula_pkg;

    // Pad, LA and memory sizes
    localparam int unsigned NUM_GPIO   = 38;
    localparam int unsigned NUM_LA     = 128;
    localparam int unsigned SRAM_WORDS = 256;

    // User area window in the management address map
    localparam logic [11:0] USER_BASE = 12'h300;

    localparam logic [3:0] REGION_SRAM = 4'd0;
    localparam logic [3:0] REGION_GPIO = 4'd1;
    localparam logic [3:0] REGION_LA   = 4'd2;
    localparam logic [3:0] REGION_TEAM = 4'd3;

    localparam logic [31:0] UNMAPPED_DATA = 32'hdead_beef;  // Read data off the map

    // One Wishbone classic request, manager to peripheral
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Peripheral answer
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [11:0] base;    // Must equal USER_BASE
        logic [3:0]  region;  // Peripheral select
        logic [15:0] offset;  // Byte offset inside the peripheral
    } wb_addr_fields_t;

    // Decoder reads base and region, peripherals read the offset
    typedef union packed {
        logic [31:0]     raw;
        wb_addr_fields_t f;
    } wb_addr_u;

    // Replace the byte lanes of a register word that sel enables
    function automatic logic [31:0] wb_merge(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  sel
    );
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- wb_decoder.sv
// ##########################################################
// Wishbone address decoder with unmapped access responder
// ##########################################################

module wb_decoder (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,

    input  nebula_pkg::wb_req_t m_req_i,
    output nebula_pkg::wb_rsp_t m_rsp_o,

    output nebula_pkg::wb_req_t sram_req_o,
    input  nebula_pkg::wb_rsp_t sram_rsp_i,
    output nebula_pkg::wb_req_t gpio_req_o,
    input  nebula_pkg::wb_rsp_t gpio_rsp_i,
    output nebula_pkg::wb_req_t la_req_o,
    input  nebula_pkg::wb_rsp_t la_rsp_i,
    output nebula_pkg::wb_req_t team_req_o,
    input  nebula_pkg::wb_rsp_t team_rsp_i
);

    nebula_pkg::wb_addr_u addr;

    logic base_hit;
    logic sel_sram, sel_gpio, sel_la, sel_team;
    logic sel_unmapped;
    logic unm_ack_q;  // Own ack for accesses nobody claims

    // Pass a request through, strobing only the selected target
    function automatic nebula_pkg::wb_req_t route(
        input nebula_pkg::wb_req_t req,
        input logic                hit
    );
        nebula_pkg::wb_req_t r;
        r     = req;
        r.cyc = req.cyc & hit;
        r.stb = req.stb & hit;
        return r;
    endfunction

    assign addr.raw = m_req_i.adr;

    assign base_hit = (addr.f.base == nebula_pkg::USER_BASE);
    assign sel_sram = base_hit && (addr.f.region == nebula_pkg::REGION_SRAM);
    assign sel_gpio = base_hit && (addr.f.region == nebula_pkg::REGION_GPIO);
    assign sel_la   = base_hit && (addr.f.region == nebula_pkg::REGION_LA);
    assign sel_team = base_hit && (addr.f.region == nebula_pkg::REGION_TEAM);

    assign sel_unmapped = ~(sel_sram | sel_gpio | sel_la | sel_team);

    assign sram_req_o = route(m_req_i, sel_sram);
    assign gpio_req_o = route(m_req_i, sel_gpio);
    assign la_req_o   = route(m_req_i, sel_la);
    assign team_req_o = route(m_req_i, sel_team);

    // Same one-cycle ack timing as the peripherals
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= m_req_i.cyc & m_req_i.stb & sel_unmapped & ~unm_ack_q;
        end
    end

    // Address is held until ack, so the mux stays on the right target
    always_comb begin
        if (sel_sram) begin
            m_rsp_o = sram_rsp_i;
        end else if (sel_gpio) begin
            m_rsp_o = gpio_rsp_i;
        end else if (sel_la) begin
            m_rsp_o = la_rsp_i;
        end else if (sel_team) begin
            m_rsp_o = team_rsp_i;
        end else begin
            m_rsp_o.ack = unm_ack_q;
            m_rsp_o.dat = nebula_pkg::UNMAPPED_DATA;
        end
    end

endmodule

//--- sram_wb.sv
// ##########################################################
// Wishbone SRAM, 256 x 32 with byte lane writes
// ##########################################################

module sram_wb (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t rsp_o
);

    localparam int unsigned AW = $clog2(nebula_pkg::SRAM_WORDS);

    nebula_pkg::wb_addr_u addr;

    logic [31:0]   mem [nebula_pkg::SRAM_WORDS];
    logic [AW-1:0] idx;
    logic          access;
    logic          ack_q;
    logic [31:0]   rdata_q;

    assign addr.raw = req_i.adr;
    assign idx      = addr.f.offset[AW+1:2];  // Upper word index bits alias

    // New strobe only, a held one is not acked twice
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= mem[idx];  // Old word, also on writes
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

//--- gpio_control.sv
// ##########################################################
// Pad ownership and firmware drive registers, pad read-back
// ##########################################################

module gpio_control (
    input  logic                              wb_clk_i,
    input  logic                              rst_n_i,
    input  nebula_pkg::wb_req_t               req_i,
    output nebula_pkg::wb_rsp_t               rsp_o,

    input  logic [nebula_pkg::NUM_GPIO-1:0]   team_gpio_out_i,
    input  logic [nebula_pkg::NUM_GPIO-1:0]   team_gpio_oeb_i,
    input  logic [nebula_pkg::NUM_GPIO-1:0]   io_in_i,
    output logic [nebula_pkg::NUM_GPIO-1:0]   io_out_o,
    output logic [nebula_pkg::NUM_GPIO-1:0]   io_oeb_o
);

    localparam int unsigned HI = nebula_pkg::NUM_GPIO - 32;  // Pads in the hi words

    nebula_pkg::wb_addr_u addr;

    logic [13:0] word;
    logic        access;
    logic        ack_q;
    logic [31:0] rd_word;
    logic [31:0] wr_word;
    logic [31:0] rdata_q;

    logic [nebula_pkg::NUM_GPIO-1:0] sel_q;  // 1 = firmware owns the pad
    logic [nebula_pkg::NUM_GPIO-1:0] out_q;
    logic [nebula_pkg::NUM_GPIO-1:0] oeb_q;

    assign addr.raw = req_i.adr;
    assign word     = addr.f.offset[15:2];
    assign access   = req_i.cyc & req_i.stb & ~ack_q;

    always_comb begin
        case (word)
            14'd0:   rd_word = sel_q[31:0];
            14'd1:   rd_word = 32'(sel_q[nebula_pkg::NUM_GPIO-1:32]);
            14'd2:   rd_word = out_q[31:0];
            14'd3:   rd_word = 32'(out_q[nebula_pkg::NUM_GPIO-1:32]);
            14'd4:   rd_word = oeb_q[31:0];
            14'd5:   rd_word = 32'(oeb_q[nebula_pkg::NUM_GPIO-1:32]);
            14'd6:   rd_word = io_in_i[31:0];
            14'd7:   rd_word = 32'(io_in_i[nebula_pkg::NUM_GPIO-1:32]);
            default: rd_word = '0;
        endcase
    end

    assign wr_word = nebula_pkg::wb_merge(rd_word, req_i.dat, req_i.sel);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            sel_q <= '0;  // Team owns every pad
            out_q <= '0;
            oeb_q <= '1;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                case (word)
                    14'd0:   sel_q[31:0] <= wr_word;
                    14'd1:   sel_q[nebula_pkg::NUM_GPIO-1:32] <= wr_word[HI-1:0];
                    14'd2:   out_q[31:0] <= wr_word;
                    14'd3:   out_q[nebula_pkg::NUM_GPIO-1:32] <= wr_word[HI-1:0];
                    14'd4:   oeb_q[31:0] <= wr_word;
                    14'd5:   oeb_q[nebula_pkg::NUM_GPIO-1:32] <= wr_word[HI-1:0];
                    default: ;  // Pad input words are read only
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    // Per pad choice between firmware and team
    assign io_out_o = (sel_q & out_q) | (~sel_q & team_gpio_out_i);
    assign io_oeb_o = (sel_q & oeb_q) | (~sel_q & team_gpio_oeb_i);

endmodule

//--- la_control.sv
// ##########################################################
// LA output ownership mask, firmware values, LA read-back
// ##########################################################

module la_control (
    input  logic                            wb_clk_i,
    input  logic                            rst_n_i,
    input  nebula_pkg::wb_req_t             req_i,
    output nebula_pkg::wb_rsp_t             rsp_o,

    input  logic [nebula_pkg::NUM_LA-1:0]   team_la_out_i,
    input  logic [nebula_pkg::NUM_LA-1:0]   la_data_i,
    output logic [nebula_pkg::NUM_LA-1:0]   la_data_o
);

    nebula_pkg::wb_addr_u addr;

    logic [13:0] word;
    logic [1:0]  lane;  // 32-bit slice inside a 128-bit group
    logic        access;
    logic        ack_q;
    logic [31:0] rd_word;
    logic [31:0] wr_word;
    logic [31:0] rdata_q;

    logic [nebula_pkg::NUM_LA-1:0] fw_q;
    logic [nebula_pkg::NUM_LA-1:0] mask_q;

    assign addr.raw = req_i.adr;
    assign word     = addr.f.offset[15:2];
    assign lane     = word[1:0];
    assign access   = req_i.cyc & req_i.stb & ~ack_q;

    // Words 0-3 value, 4-7 mask, 8-11 LA inputs
    always_comb begin
        rd_word = '0;
        if (word < 14'd4) begin
            rd_word = fw_q[32*lane +: 32];
        end else if (word < 14'd8) begin
            rd_word = mask_q[32*lane +: 32];
        end else if (word < 14'd12) begin
            rd_word = la_data_i[32*lane +: 32];
        end
    end

    assign wr_word = nebula_pkg::wb_merge(rd_word, req_i.dat, req_i.sel);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            fw_q   <= '0;
            mask_q <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                if (word < 14'd4) begin
                    fw_q[32*lane +: 32] <= wr_word;
                end else if (word < 14'd8) begin
                    mask_q[32*lane +: 32] <= wr_word;
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    assign la_data_o = (mask_q & fw_q) | (~mask_q & team_la_out_i);

endmodule

//--- team_counter.sv
// ##########################################################
// Sample team design, loadable free-running counter
// ##########################################################

module team_counter (
    input  logic                              wb_clk_i,
    input  logic                              rst_n_i,
    input  nebula_pkg::wb_req_t               req_i,
    output nebula_pkg::wb_rsp_t               rsp_o,

    input  logic [31:0]                       gpio_in_i,
    output logic [nebula_pkg::NUM_GPIO-1:0]   gpio_out_o,
    output logic [nebula_pkg::NUM_GPIO-1:0]   gpio_oeb_o,
    output logic [nebula_pkg::NUM_LA-1:0]     la_out_o
);

    nebula_pkg::wb_addr_u addr;

    logic [13:0] word;
    logic        access;
    logic        load;
    logic        ack_q;
    logic        en_q;
    logic [31:0] count_q;
    logic [31:0] rd_word;
    logic [31:0] wr_word;
    logic [31:0] rdata_q;

    assign addr.raw = req_i.adr;
    assign word     = addr.f.offset[15:2];
    assign access   = req_i.cyc & req_i.stb & ~ack_q;
    assign load     = access & req_i.we & (word == 14'd1);

    always_comb begin
        case (word)
            14'd0:   rd_word = {31'b0, en_q};
            14'd1:   rd_word = count_q;
            14'd2:   rd_word = gpio_in_i;
            default: rd_word = '0;
        endcase
    end

    assign wr_word = nebula_pkg::wb_merge(rd_word, req_i.dat, req_i.sel);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            en_q    <= 1'b0;
            count_q <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && (word == 14'd0)) begin
                en_q <= wr_word[0];
            end
            if (load) begin
                count_q <= wr_word;  // Load wins over counting
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    // Count shown on pads and LA, pads always driven
    assign gpio_out_o = {{(nebula_pkg::NUM_GPIO - 32){1'b0}}, count_q};
    assign gpio_oeb_o = '0;
    assign la_out_o   = {{(nebula_pkg::NUM_LA - 32){1'b0}}, count_q};

endmodule

//--- nebula_top.sv
// ##########################################################
// User area top with Wishbone decoder, SRAM, pad and LA
// control and the sample team counter
// ##########################################################

module nebula_top (
    input  logic                                 wb_clk_i,
    input  logic                                 rst_n_i,

    input  nebula_pkg::wb_req_t                  wbs_req_i,
    output nebula_pkg::wb_rsp_t                  wbs_rsp_o,

    input  logic [nebula_pkg::NUM_LA-1:0]        la_data_i,
    output logic [nebula_pkg::NUM_LA-1:0]        la_data_o,
    input  logic [nebula_pkg::NUM_LA-1:0]        la_oenb_i,  // Management side direction, not used here

    input  logic [nebula_pkg::NUM_GPIO-1:0]      io_in_i,
    output logic [nebula_pkg::NUM_GPIO-1:0]      io_out_o,
    output logic [nebula_pkg::NUM_GPIO-1:0]      io_oeb_o
);

    nebula_pkg::wb_req_t sram_req, gpio_req, la_req, team_req;
    nebula_pkg::wb_rsp_t sram_rsp, gpio_rsp, la_rsp, team_rsp;

    // Team design pin requests, before ownership muxing
    logic [nebula_pkg::NUM_GPIO-1:0] team_gpio_out;
    logic [nebula_pkg::NUM_GPIO-1:0] team_gpio_oeb;
    logic [nebula_pkg::NUM_LA-1:0]   team_la_out;

    wb_decoder u_decoder (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .m_req_i    (wbs_req_i),
        .m_rsp_o    (wbs_rsp_o),
        .sram_req_o (sram_req),
        .sram_rsp_i (sram_rsp),
        .gpio_req_o (gpio_req),
        .gpio_rsp_i (gpio_rsp),
        .la_req_o   (la_req),
        .la_rsp_i   (la_rsp),
        .team_req_o (team_req),
        .team_rsp_i (team_rsp)
    );

    sram_wb u_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (sram_req),
        .rsp_o    (sram_rsp)
    );

    gpio_control u_gpio (
        .wb_clk_i        (wb_clk_i),
        .rst_n_i         (rst_n_i),
        .req_i           (gpio_req),
        .rsp_o           (gpio_rsp),
        .team_gpio_out_i (team_gpio_out),
        .team_gpio_oeb_i (team_gpio_oeb),
        .io_in_i         (io_in_i),
        .io_out_o        (io_out_o),
        .io_oeb_o        (io_oeb_o)
    );

    la_control u_la (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (la_req),
        .rsp_o         (la_rsp),
        .team_la_out_i (team_la_out),
        .la_data_i     (la_data_i),
        .la_data_o     (la_data_o)
    );

    // Sample team slot
    team_counter u_team (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (team_req),
        .rsp_o      (team_rsp),
        .gpio_in_i  (io_in_i[31:0]),
        .gpio_out_o (team_gpio_out),
        .gpio_oeb_o (team_gpio_oeb),
        .la_out_o   (team_la_out)
    );

endmodule

//--- tb_nebula.sv
// ##########################################################
// Directed testbench for the user area top, with Wishbone
// bus tasks, an LFSR data source and the tests
// ##########################################################

module tb_nebula;

    localparam int unsigned ACK_TIMEOUT = 16;  // Cycles to wait for an ack

    logic                            clk;
    logic                            rst_n;
    nebula_pkg::wb_req_t             wbs_req;
    nebula_pkg::wb_rsp_t             wbs_rsp;
    logic [nebula_pkg::NUM_LA-1:0]   la_in;
    logic [nebula_pkg::NUM_LA-1:0]   la_out;
    logic [nebula_pkg::NUM_LA-1:0]   la_oenb;
    logic [nebula_pkg::NUM_GPIO-1:0] io_in;
    logic [nebula_pkg::NUM_GPIO-1:0] io_out;
    logic [nebula_pkg::NUM_GPIO-1:0] io_oeb;

    int unsigned errors;
    int unsigned checks;
    int unsigned tests;
    logic [31:0] lfsr;
    logic [31:0] sram_model [nebula_pkg::SRAM_WORDS];  // Expected memory contents

    nebula_top u_dut (
        .wb_clk_i  (clk),
        .rst_n_i   (rst_n),
        .wbs_req_i (wbs_req),
        .wbs_rsp_o (wbs_rsp),
        .la_data_i (la_in),
        .la_data_o (la_out),
        .la_oenb_i (la_oenb),
        .io_in_i   (io_in),
        .io_out_o  (io_out),
        .io_oeb_o  (io_oeb)
    );

    always #4 clk = ~clk;

    task automatic check_eq(input string what, input logic [127:0] got,
                            input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};  // One step per bit
        end
    endtask

    function automatic logic [31:0] user_addr(input logic [3:0] region, input logic [13:0] word);
        return {nebula_pkg::USER_BASE, region, word, 2'b00};
    endfunction

    // One classic cycle, held until ack, stb dropped on the next edge
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int unsigned waited;
        @(posedge clk);
        #1;
        wbs_req.cyc = 1'b1;
        wbs_req.stb = 1'b1;
        wbs_req.we  = we;
        wbs_req.sel = sel;
        wbs_req.adr = adr;
        wbs_req.dat = wdat;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wbs_rsp.ack && waited < ACK_TIMEOUT);
        if (!wbs_rsp.ack) begin
            $display("timeout: no ack for the access at address %h", adr);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            rdat = wbs_rsp.dat;
            // First negedge comes before the sampling edge
            check_eq("ack delay in cycles", 128'(waited - 1), 128'(1));
            @(posedge clk);
            #1;
            wbs_req.cyc = 1'b0;
            wbs_req.stb = 1'b0;
            wbs_req.we  = 1'b0;
            @(negedge clk);
            check_eq("ack low one cycle later", 128'(wbs_rsp.ack), 128'(0));  // Single-cycle ack
        end
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] old_word;
        bus_cycle(1'b1, adr, dat, sel, old_word);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'h0, 4'hf, dat);
    endtask

    task automatic finish_test(input string name, input int unsigned errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_sram();
        int unsigned e0;
        logic [13:0] idx [5];
        logic [31:0] w;
        logic [31:0] got;
        logic [3:0]  lanes;
        e0  = errors;
        idx = '{14'd0, 14'd1, 14'd17, 14'd200, 14'd255};
        for (int i = 0; i < 5; i++) begin
            rand_word(w);
            sram_model[idx[i][7:0]] = w;
            wb_write(user_addr(nebula_pkg::REGION_SRAM, idx[i]), w, 4'hf);
        end
        lanes = 4'b0101;  // Bytes 0 and 2 only
        rand_word(w);
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                sram_model[17][8*b +: 8] = w[8*b +: 8];
            end
        end
        wb_write(user_addr(nebula_pkg::REGION_SRAM, 14'd17), w, lanes);
        for (int i = 0; i < 5; i++) begin
            wb_read(user_addr(nebula_pkg::REGION_SRAM, idx[i]), got);
            check_eq($sformatf("sram word %0d", idx[i]), 128'(got), 128'(sram_model[idx[i][7:0]]));
        end
        finish_test("sram", e0);
    endtask

    task automatic test_unmapped();
        int unsigned e0;
        logic [31:0] got;
        e0 = errors;
        wb_read({nebula_pkg::USER_BASE, 4'd5, 16'h0010}, got);
        check_eq("region 5 read data", 128'(got), 128'(32'hdead_beef));
        wb_read({12'h301, nebula_pkg::REGION_SRAM, 16'h0000}, got);
        check_eq("wrong base read data", 128'(got), 128'(32'hdead_beef));
        // Would land on SRAM word 0 if the base were ignored
        wb_write({12'h301, nebula_pkg::REGION_SRAM, 16'h0000}, ~sram_model[0], 4'hf);
        wb_read(user_addr(nebula_pkg::REGION_SRAM, 14'd0), got);
        check_eq("sram word 0 after unmapped write", 128'(got), 128'(sram_model[0]));
        finish_test("unmapped", e0);
    endtask

    task automatic test_team();
        int unsigned e0;
        logic [31:0] load_val;
        logic [31:0] first;
        logic [31:0] second;
        e0 = errors;
        @(negedge clk);
        check_eq("io_oeb after reset", 128'(io_oeb), 128'(0));
        rand_word(load_val);
        load_val[31] = 1'b0;  // No wrap between the two reads
        wb_write(user_addr(nebula_pkg::REGION_TEAM, 14'd1), load_val, 4'hf);
        @(negedge clk);
        check_eq("io_out count bits", 128'(io_out[31:0]), 128'(load_val));
        check_eq("io_out upper pads", 128'(io_out[37:32]), 128'(0));
        check_eq("la_data_o count bits", 128'(la_out[31:0]), 128'(load_val));
        wb_write(user_addr(nebula_pkg::REGION_TEAM, 14'd0), 32'h1, 4'hf);
        wb_read(user_addr(nebula_pkg::REGION_TEAM, 14'd1), first);
        wb_read(user_addr(nebula_pkg::REGION_TEAM, 14'd1), second);
        check_eq("count increases", 128'(second > first), 128'(1));
        finish_test("team counter", e0);
    endtask

    task automatic test_gpio();
        int unsigned e0;
        logic [37:0] sel_m;
        logic [37:0] out_v;
        logic [37:0] oeb_v;
        logic [37:0] in_v;
        logic [37:0] exp_out;
        logic [31:0] w;
        logic [31:0] count_v;
        logic [31:0] got;
        e0 = errors;
        wb_write(user_addr(nebula_pkg::REGION_TEAM, 14'd0), 32'h0, 4'hf);  // Stop the counter
        wb_read(user_addr(nebula_pkg::REGION_TEAM, 14'd1), count_v);
        sel_m = 38'h2a_0f00_00f0;
        wb_write(user_addr(nebula_pkg::REGION_GPIO, 14'd0), sel_m[31:0], 4'hf);
        wb_write(user_addr(nebula_pkg::REGION_GPIO, 14'd1), 32'(sel_m[37:32]), 4'hf);
        rand_word(w);
        out_v[31:0] = w;
        wb_write(user_addr(nebula_pkg::REGION_GPIO, 14'd2), w, 4'hf);
        rand_word(w);
        out_v[37:32] = w[5:0];  // Only 6 pads above bit 31
        wb_write(user_addr(nebula_pkg::REGION_GPIO, 14'd3), w, 4'hf);
        rand_word(w);
        oeb_v[31:0] = w;
        wb_write(user_addr(nebula_pkg::REGION_GPIO, 14'd4), w, 4'hf);
        rand_word(w);
        oeb_v[37:32] = w[5:0];
        wb_write(user_addr(nebula_pkg::REGION_GPIO, 14'd5), w, 4'hf);
        @(negedge clk);
        exp_out = (sel_m & out_v) | (~sel_m & {6'b0, count_v});
        check_eq("io_out mix", 128'(io_out), 128'(exp_out));
        check_eq("io_oeb mix", 128'(io_oeb), 128'(sel_m & oeb_v));
        @(posedge clk);
        #1;
        rand_word(w);
        io_in[31:0] = w;
        rand_word(w);
        io_in[37:32] = w[5:0];
        in_v = io_in;
        wb_read(user_addr(nebula_pkg::REGION_GPIO, 14'd6), got);
        check_eq("pad inputs low", 128'(got), 128'(in_v[31:0]));
        wb_read(user_addr(nebula_pkg::REGION_GPIO, 14'd7), got);
        check_eq("pad inputs high", 128'(got), 128'({26'b0, in_v[37:32]}));
        finish_test("gpio takeover", e0);
    endtask

    task automatic test_la();
        int unsigned e0;
        logic [127:0] fw_v;
        logic [127:0] mask_v;
        logic [127:0] in_v;
        logic [127:0] exp_v;
        logic [31:0]  w;
        logic [31:0]  count_v;
        logic [31:0]  got;
        e0 = errors;
        wb_read(user_addr(nebula_pkg::REGION_TEAM, 14'd1), count_v);  // Counter still stopped
        for (int i = 0; i < 4; i++) begin
            rand_word(w);
            fw_v[32*i +: 32] = w;
            wb_write(user_addr(nebula_pkg::REGION_LA, 14'(i)), w, 4'hf);
        end
        for (int i = 0; i < 4; i++) begin
            rand_word(w);
            mask_v[32*i +: 32] = w;
            wb_write(user_addr(nebula_pkg::REGION_LA, 14'(i + 4)), w, 4'hf);
        end
        @(negedge clk);
        exp_v = (mask_v & fw_v) | (~mask_v & {96'b0, count_v});
        check_eq("la_data_o mix", la_out, exp_v);
        @(posedge clk);
        #1;
        for (int i = 0; i < 4; i++) begin
            rand_word(w);
            la_in[32*i +: 32] = w;
        end
        in_v = la_in;
        for (int i = 0; i < 4; i++) begin
            wb_read(user_addr(nebula_pkg::REGION_LA, 14'(i + 8)), got);
            check_eq($sformatf("la input word %0d", i), 128'(got), 128'(in_v[32*i +: 32]));
        end
        finish_test("la takeover", e0);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        wbs_req = '0;
        la_in   = '0;
        la_oenb = '1;
        io_in   = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        lfsr    = 32'hd2c4_0eab;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_sram();
        test_unmapped();
        test_team();
        test_gpio();
        test_la();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
nebula_pkg.sv
wb_decoder.sv
sram_wb.sv
gpio_control.sv
la_control.sv
team_counter.sv
nebula_top.sv
tb_nebula.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_nebula
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

# Every line of the file list is a source path
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
